/* bcdFieldEditor.sv */
`timescale 1ns/100ps
`include "cronoDefs_defs.svh"

module bcdFieldEditor (
    input  logic               clk,
    input  logic               Reset,
    input  logic               editEnable,
    input  crono_pkg::navPulseT navPulse,
    output crono_pkg::timeValT  targetTime,
    output logic [7:0]         cursor
);

    import crono_pkg::*;

    fieldSelT   field;
    bcdByteT    curByte;    // Byte under the cursor
    bcdByteT    stepByte;
    logic [7:0] maxVal;

    // One BCD step up or down with wrap at 00 and at the field top
    function automatic bcdByteT bcdStep(input bcdByteT cur, input logic incr,
                                        input logic [7:0] top);
        bcdByteT nxt;
        nxt = cur;
        if (incr) begin
            if (cur.raw == top) begin
                nxt.raw = 8'h00;
            end else if (cur.digit.units == 4'd9) begin
                nxt.digit.tens  = cur.digit.tens + 4'd1;
                nxt.digit.units = 4'd0;
            end else begin
                nxt.digit.units = cur.digit.units + 4'd1;
            end
        end else begin
            if (cur.raw == 8'h00) begin
                nxt.raw = top;
            end else if (cur.digit.units == 4'd0) begin
                nxt.digit.tens  = cur.digit.tens - 4'd1;
                nxt.digit.units = 4'd9;
            end else begin
                nxt.digit.units = cur.digit.units - 4'd1;
            end
        end
        return nxt;
    endfunction

    always_comb begin
        case (field)
            FIELD_MIN: begin
                curByte = targetTime.minutes;
                maxVal  = `BCD_MAX_MINSEC;
            end
            FIELD_HOUR: begin
                curByte = targetTime.hours;
                maxVal  = `BCD_MAX_HOUR;
            end
            default: begin
                curByte = targetTime.seconds;
                maxVal  = `BCD_MAX_MINSEC;
            end
        endcase
        stepByte = bcdStep(curByte, navPulse.up, maxVal);
    end

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            field      <= FIELD_SEC;
            targetTime <= '0;
        end else if (editEnable) begin
            if (navPulse.up || navPulse.down) begin
                case (field)
                    FIELD_MIN:  targetTime.minutes <= stepByte;
                    FIELD_HOUR: targetTime.hours   <= stepByte;
                    default:    targetTime.seconds <= stepByte;
                endcase
            end
            if (navPulse.left && field != FIELD_HOUR)
                field <= (field == FIELD_SEC) ? FIELD_MIN : FIELD_HOUR;
            if (navPulse.right && field != FIELD_SEC)   // Stops at seconds
                field <= (field == FIELD_HOUR) ? FIELD_MIN : FIELD_SEC;
        end else begin
            field <= FIELD_SEC;     // Editing starts again at seconds
        end
    end

    always_comb begin
        if (!editEnable) cursor = `CURSOR_OFF;     // Hidden outside programming
        else if (field == FIELD_MIN) cursor = `CURSOR_MIN;
        else if (field == FIELD_HOUR) cursor = `CURSOR_HOUR;
        else cursor = `CURSOR_SEC;
    end

endmodule

/* cronoChecker.sv */
`timescale 1ns/100ps

module cronoChecker (
    input  logic               clk,
    input  crono_pkg::timeValT targetTime,
    input  logic [7:0]         cursor,
    input  logic               cronoActive,
    input  logic               ring,
    input  logic               awValid,
    input  logic               wValid,
    input  integer             wrCount,
    input  logic [7:0]         wrData,
    input  logic [7:0]         wrAddr
);

    import crono_pkg::*;

    localparam integer WAIT_LIMIT = 64;    // Cycles allowed for a value to appear

    integer testNum = 0;
    integer testCount = 0;
    integer testChecks = 0;
    integer testErrors = 0;
    integer checkCount = 0;
    integer errCount = 0;

    function automatic logic knownSignal(input string sig);
        return (sig == "tgt" || sig == "cur" || sig == "act" || sig == "ring" ||
                sig == "awv" || sig == "wv" || sig == "wrcnt" || sig == "wrdata" ||
                sig == "wraddr");
    endfunction

    function automatic logic [23:0] pickValue(input string sig);
        logic [23:0] val;
        val = '0;
        if (sig == "tgt") val = targetTime;
        else if (sig == "cur") val = {16'h0, cursor};
        else if (sig == "act") val = {23'h0, cronoActive};
        else if (sig == "ring") val = {23'h0, ring};
        else if (sig == "awv") val = {23'h0, awValid};
        else if (sig == "wv") val = {23'h0, wValid};
        else if (sig == "wrcnt") val = wrCount[23:0];
        else if (sig == "wrdata") val = {16'h0, wrData};
        else if (sig == "wraddr") val = {16'h0, wrAddr};
        return val;
    endfunction

    task automatic reportFailure(input string msg);
        $display("%0t: %s", $time, msg);
        errCount++;
        testErrors++;
    endtask

    task automatic finishTest();
        if (testNum != 0)
            $display("test %0d done: %0d checks, %0d errors", testNum, testChecks, testErrors);
    endtask

    task automatic startTest(input integer num);
        finishTest();
        testNum    = num;
        testCount++;
        testChecks = 0;
        testErrors = 0;
    endtask

    // hold == 0 waits for the value, otherwise it must stay for hold cycles
    task automatic expectValue(input string sig, input integer hold, input logic [23:0] expv);
        logic [23:0] act;
        integer      n;
        logic        ok;
        checkCount++;
        testChecks++;
        if (!knownSignal(sig)) begin
            reportFailure({"stimulus names an unknown signal: ", sig});
        end else begin
            n   = 0;
            ok  = 1'b1;
            act = pickValue(sig);
            if (hold == 0) begin
                while (act !== expv && n < WAIT_LIMIT) begin
                    @(negedge clk);
                    act = pickValue(sig);
                    n++;
                end
                ok = (act === expv);
                if (!ok)
                    $display("%0t: %s did not reach the expected value within %0d cycles",
                             $time, sig, WAIT_LIMIT);
            end else begin
                while (ok && n < hold) begin
                    @(negedge clk);
                    act = pickValue(sig);
                    ok  = (act === expv);
                    n++;
                end
            end
            if (!ok) begin
                $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, sig, expv, act);
                errCount++;
                testErrors++;
            end
        end
    endtask

    task automatic reportTotals();
        finishTest();
        $display("totals: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
    endtask

endmodule

/* cronoControl.sv */
`timescale 1ns/100ps
`include "cronoDefs_defs.svh"

module cronoControl (
    input  logic              clk,
    input  logic              Reset,
    input  logic              programMode,
    input  logic              startRun,
    input  crono_pkg::timeValT rtcTime,
    input  crono_pkg::timeValT targetTime,
    output logic              editEnable,
    output logic              cronoActive,
    output logic              ring,
    output logic              runReq,
    output logic              stopReq,
    output logic [7:0]        runData
);

    import crono_pkg::*;

    cronoStateT state;
    cronoStateT nextState;
    logic       matchReg;   // Target reached, one cycle behind rtcTime

    always_comb begin
        nextState = state;
        if (programMode) begin
            nextState = ST_PROGRAM;
        end else begin
            case (state)
                ST_PROGRAM: nextState = startRun ? ST_RUNNING : ST_IDLE;
                ST_IDLE: begin
                    if (matchReg) nextState = ST_RINGING;
                    else if (startRun) nextState = ST_RUNNING;
                end
                ST_RUNNING: begin
                    if (matchReg) nextState = ST_RINGING;
                    else if (!startRun) nextState = ST_IDLE;
                end
                default: nextState = ST_RINGING;    // Held until programMode
            endcase
        end
    end

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            state    <= ST_PROGRAM;
            matchReg <= 1'b0;
            runReq   <= 1'b0;
            stopReq  <= 1'b0;
        end else begin
            state    <= nextState;
            matchReg <= (rtcTime == targetTime) && (targetTime != '0);
            runReq   <= (nextState == ST_RUNNING) && (state != ST_RUNNING);
            stopReq  <= (state == ST_RUNNING) && (nextState != ST_RUNNING);
        end
    end

    // Data for the RTC write, sampled together with the request pulse
    always_ff @(posedge clk) begin
        if (nextState == ST_RUNNING && state != ST_RUNNING) runData <= `RTC_RUN_DATA;
        else if (state == ST_RUNNING && nextState != ST_RUNNING) runData <= `RTC_STOP_DATA;
    end

    assign editEnable  = (state == ST_PROGRAM);
    assign cronoActive = (state == ST_RUNNING);
    assign ring        = (state == ST_RINGING);

endmodule

/* cronoDefs_defs.svh */
`ifndef CRONO_DEFS_SVH
`define CRONO_DEFS_SVH

// Cursor codes shown on the display
`define CURSOR_SEC      8'h41
`define CURSOR_MIN      8'h42
`define CURSOR_HOUR     8'h43
`define CURSOR_OFF      8'h00

// RTC control register
`define RTC_CTRL_ADDR   8'h00
`define RTC_RUN_DATA    8'h10   // Starts the RTC count
`define RTC_STOP_DATA   8'h00

// Top of each BCD field
`define BCD_MAX_MINSEC  8'h59
`define BCD_MAX_HOUR    8'h23

`endif

/* cronoTimer.sv */
`timescale 1ns/100ps

module cronoTimer (
    input  logic                clk,
    input  logic                Reset,
    input  logic                programMode,
    input  logic                startRun,
    input  logic                up,
    input  logic                down,
    input  logic                left,
    input  logic                right,
    input  crono_pkg::timeValT   rtcTime,
    input  crono_pkg::axilWrRspT rtcRsp,
    output crono_pkg::timeValT   targetTime,
    output logic [7:0]          cursor,
    output logic                cronoActive,
    output logic                ring,
    output crono_pkg::axilWrReqT rtcReq
);

    import crono_pkg::*;

    navPulseT   navPulse;
    logic       editEnable;
    logic       runReq, stopReq;
    logic [7:0] runData;    // RTC control value for the next write

    navEdgeDetect navEdgeDetect_i (
        .clk, .Reset, .up, .down, .left, .right, .navPulse
    );

    bcdFieldEditor bcdFieldEditor_i (
        .clk, .Reset, .editEnable, .navPulse, .targetTime, .cursor
    );

    cronoControl cronoControl_i (
        .clk, .Reset, .programMode, .startRun, .rtcTime, .targetTime,
        .editEnable, .cronoActive, .ring, .runReq, .stopReq, .runData
    );

    rtcWriteMaster rtcWriteMaster_i (
        .clk, .Reset, .runReq, .stopReq, .runData, .rtcRsp, .rtcReq
    );

endmodule

/* cronoTimer_properties.sv */
`timescale 1ns/100ps

module cronoTimer_properties (
    input logic                 clk,
    input logic                 Reset,
    input logic                 programMode,
    input crono_pkg::axilWrReqT rtcReq,
    input crono_pkg::axilWrRspT rtcRsp,
    input logic                 ring,
    input crono_pkg::navPulseT  navPulse
);

    import crono_pkg::*;

    integer assertFails = 0;    // Failed assertions so far

    awHeld: assert property (@(posedge clk) disable iff (Reset)
        rtcReq.awValid && !rtcRsp.awReady |=> rtcReq.awValid)
        else begin
            $error("awValid dropped before awReady");
            assertFails++;
        end

    wHeld: assert property (@(posedge clk) disable iff (Reset)
        rtcReq.wValid && !rtcRsp.wReady |=> rtcReq.wValid)
        else begin
            $error("wValid dropped before wReady");
            assertFails++;
        end

    wDataStable: assert property (@(posedge clk) disable iff (Reset)
        rtcReq.wValid && !rtcRsp.wReady |=> $stable(rtcReq.wData))
        else begin
            $error("wData changed while valid");
            assertFails++;
        end

    // Only programMode ends the alarm
    ringHeld: assert property (@(posedge clk) disable iff (Reset)
        ring && !programMode |=> ring)
        else begin
            $error("ring dropped without programMode");
            assertFails++;
        end

    // A press gives one pulse, never two in a row
    navSingle: assert property (@(posedge clk) disable iff (Reset)
        (navPulse & $past(navPulse)) == 4'b0000)
        else begin
            $error("nav pulse longer than one cycle");
            assertFails++;
        end

endmodule

bind cronoTimer cronoTimer_properties cronoTimer_properties_i (
    .clk, .Reset, .programMode, .rtcReq, .rtcRsp, .ring, .navPulse
);

/* crono_pkg.sv */
package crono_pkg;

    // One time byte, either as a plain byte or as two BCD digits
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] tens;
            logic [3:0] units;
        } digit;
    } bcdByteT;

    typedef struct packed {
        bcdByteT hours;
        bcdByteT minutes;
        bcdByteT seconds;
    } timeValT;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } navPulseT;

    typedef enum logic [1:0] {FIELD_SEC, FIELD_MIN, FIELD_HOUR} fieldSelT;

    typedef enum logic [1:0] {ST_PROGRAM, ST_IDLE, ST_RUNNING, ST_RINGING} cronoStateT;

    // Master side of the AXI4-Lite write channels
    typedef struct packed {
        logic       awValid;
        logic [7:0] awAddr;
        logic       wValid;
        logic [7:0] wData;
        logic       bReady;
    } axilWrReqT;

    typedef struct packed {
        logic       awReady;
        logic       wReady;
        logic       bValid;
        logic [1:0] bResp;
    } axilWrRspT;

endpackage

/* crono_stimulus.txt */
# op operand expected (hex). press: 0 up 1 down 2 left 3 right
# check ops name a signal, operand 0 waits for it, otherwise holds that many cycles
test 1 0
ring 0 0
act 0 0
awv 0 0
wv 0 0
tgt 0 000000
cur 0 41
test 2 0
press 0 0
tgt 0 000001
press 1 0
tgt 0 000000
press 1 0
tgt 0 000059
press 0 0
tgt 0 000000
press 1 0
press 1 0
tgt 0 000058
press 0 0
tgt 0 000059
test 3 0
press 2 0
cur 0 42
press 2 0
cur 0 43
press 1 0
tgt 0 230059
press 0 0
tgt 0 000059
press 3 0
cur 0 42
prog 0 0
cur 0 00
press 0 0
tgt 0 000059
test 4 0
start 1 0
act 0 1
wrcnt 0 1
wrdata 0 10
wraddr 0 00
start 0 0
act 0 0
wrcnt 0 2
wrdata 0 00
test 5 0
start 1 0
act 0 1
wrcnt 0 3
rtc 000059 0
ring 0 1
act 0 0
wrcnt 0 4
wrdata 0 00
ring 10 1
prog 1 0
ring 0 0
cur 0 41
press 0 0
tgt 0 000000
prog 0 0
act 0 1
wrcnt 0 5
rtc 000000 0
ring 10 0
start 0 0
wrcnt 0 6

/* navEdgeDetect.sv */
`timescale 1ns/100ps

module navEdgeDetect (
    input  logic               clk,
    input  logic               Reset,
    input  logic               up,
    input  logic               down,
    input  logic               left,
    input  logic               right,
    output crono_pkg::navPulseT navPulse
);

    logic [3:0] syncMeta;   // First synchroniser stage
    logic [3:0] syncBtn;
    logic [3:0] lastBtn;    // Previous synchronised sample
    logic [3:0] rise;

    assign rise = syncBtn & ~lastBtn;   // Bit order up, down, left, right

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            syncMeta <= '0;
            syncBtn  <= '0;
            lastBtn  <= '0;
            navPulse <= '0;
        end else begin
            syncMeta <= {up, down, left, right};
            syncBtn  <= syncMeta;
            lastBtn  <= syncBtn;
            navPulse <= '0;
            // Only one press per cycle, up wins
            if (rise[3])      navPulse.up    <= 1'b1;
            else if (rise[2]) navPulse.down  <= 1'b1;
            else if (rise[1]) navPulse.left  <= 1'b1;
            else if (rise[0]) navPulse.right <= 1'b1;
        end
    end

endmodule

/* rtcWriteMaster.sv */
`timescale 1ns/100ps
`include "cronoDefs_defs.svh"

module rtcWriteMaster (
    input  logic                clk,
    input  logic                Reset,
    input  logic                runReq,
    input  logic                stopReq,
    input  logic [7:0]          runData,
    input  crono_pkg::axilWrRspT rtcRsp,
    output crono_pkg::axilWrReqT rtcReq
);

    logic       awValid, wValid, bReady;
    logic [7:0] wData;
    logic       pendValid;  // One waiting request
    logic [7:0] pendData;
    logic       reqIn, busy, respDone, launch;

    assign reqIn    = runReq | stopReq;
    assign busy     = awValid | wValid | bReady;
    assign respDone = bReady & rtcRsp.bValid;
    assign launch   = (!busy || respDone) && (reqIn || pendValid);

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            awValid   <= 1'b0;
            wValid    <= 1'b0;
            bReady    <= 1'b0;
            pendValid <= 1'b0;
        end else begin
            if (awValid && rtcRsp.awReady) awValid <= 1'b0;
            if (wValid && rtcRsp.wReady) wValid <= 1'b0;
            // Both channels finish this cycle or earlier
            if ((awValid || wValid) && (!awValid || rtcRsp.awReady)
                && (!wValid || rtcRsp.wReady))
                bReady <= 1'b1;
            if (respDone) bReady <= 1'b0;   // bResp not checked
            if (launch) begin
                awValid   <= 1'b1;
                wValid    <= 1'b1;
                pendValid <= 1'b0;
            end else if (reqIn) begin
                pendValid <= 1'b1;  // Latest request wins
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) wData <= reqIn ? runData : pendData;
        if (reqIn && !launch) pendData <= runData;
    end

    assign rtcReq = '{awValid: awValid, awAddr: `RTC_CTRL_ADDR, wValid: wValid,
                      wData: wData, bReady: bReady};

endmodule

/* tb.f */
+incdir+.
crono_pkg.sv
navEdgeDetect.sv
bcdFieldEditor.sv
cronoControl.sv
rtcWriteMaster.sv
cronoTimer.sv
tbClockGen.sv
cronoChecker.sv
cronoTimer_properties.sv
tb_cronoTimer.sv

/* tbClockGen.sv */
`timescale 1ns/100ps

module tbClockGen (
    output logic clk,
    output logic Reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    initial begin
        Reset = 1'b1;
        repeat (3) @(posedge clk);
        #2 Reset = 1'b0;
    end

endmodule

/* tb_cronoTimer.sv */
`timescale 1ns/100ps

module tb_cronoTimer;

    import crono_pkg::*;

    logic       clk, Reset;
    logic       programMode, startRun, up, down, left, right;
    timeValT    rtcTime, targetTime;
    axilWrRspT  rtcRsp;
    axilWrReqT  rtcReq;
    logic [7:0] cursor;
    logic       cronoActive, ring;

    integer     seed = 90;
    integer     wrCount = 0;        // Completed RTC writes
    logic [7:0] wrData = '0;
    logic [7:0] wrAddr = '0;

    tbClockGen clockGen_i (.clk, .Reset);

    cronoTimer cronoTimer_i (
        .clk, .Reset, .programMode, .startRun, .up, .down, .left, .right,
        .rtcTime, .rtcRsp, .targetTime, .cursor, .cronoActive, .ring, .rtcReq
    );

    cronoChecker checker_i (
        .clk, .targetTime, .cursor, .cronoActive, .ring,
        .awValid(rtcReq.awValid), .wValid(rtcReq.wValid),
        .wrCount, .wrData, .wrAddr
    );

    task automatic stepCycles(input integer n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic pressButton(input integer which);
        up    = (which == 0);
        down  = (which == 1);
        left  = (which == 2);
        right = (which == 3);
        stepCycles(4);
        {up, down, left, right} = 4'b0000;
        stepCycles(4);
    endtask

    // RTC slave with random ready and response delays
    initial begin
        logic       awHs, wHs, bHs, awGot, wGot;
        logic [7:0] sAddr, sData, gotAddr, gotData;
        integer     awWait, wWait, bWait;
        rtcRsp = '0;
        awGot  = 1'b0;
        wGot   = 1'b0;
        awWait = $unsigned($random(seed)) % 4;
        wWait  = $unsigned($random(seed)) % 4;
        bWait  = $unsigned($random(seed)) % 4;
        forever begin
            @(posedge clk);
            awHs  = rtcReq.awValid && rtcRsp.awReady;
            wHs   = rtcReq.wValid && rtcRsp.wReady;
            bHs   = rtcRsp.bValid && rtcReq.bReady;
            sAddr = rtcReq.awAddr;
            sData = rtcReq.wData;
            #2;
            if (awHs) begin
                rtcRsp.awReady = 1'b0;
                awGot   = 1'b1;
                gotAddr = sAddr;
                awWait  = $unsigned($random(seed)) % 4;
            end else if (rtcReq.awValid && !rtcRsp.awReady) begin
                if (awWait == 0) rtcRsp.awReady = 1'b1;
                else awWait--;
            end
            if (wHs) begin
                rtcRsp.wReady = 1'b0;
                wGot    = 1'b1;
                gotData = sData;
                wWait   = $unsigned($random(seed)) % 4;
            end else if (rtcReq.wValid && !rtcRsp.wReady) begin
                if (wWait == 0) rtcRsp.wReady = 1'b1;
                else wWait--;
            end
            if (bHs) begin
                rtcRsp.bValid = 1'b0;
                awGot   = 1'b0;
                wGot    = 1'b0;
                wrAddr  = gotAddr;
                wrData  = gotData;
                wrCount++;
                bWait   = $unsigned($random(seed)) % 4;
                $display("%0t: RTC write %0d addr=%h data=%h", $time, wrCount, wrAddr, wrData);
            end else if (awGot && wGot && !rtcRsp.bValid) begin
                if (bWait == 0) rtcRsp.bValid = 1'b1;
                else bWait--;
            end
        end
    end

    initial begin
        #2_000_000;
        $display("Simulation ran too long, stimulus did not finish");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        integer fd, n, operand;
        string  lineBuf, opName;
        logic [23:0] expVal;
        programMode = 1'b1;
        startRun    = 1'b0;
        {up, down, left, right} = 4'b0000;
        rtcTime     = '0;
        fd = $fopen("crono_stimulus.txt", "r");
        n  = 0;
        while (Reset !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (fd == 0 || Reset !== 1'b0) begin
            $display("Could not open the stimulus file or reset never ended");
            $display("TEST FAILED");
            $finish;
        end else begin
            stepCycles(1);
            while (!$feof(fd)) begin
                n = $fgets(lineBuf, fd);
                if (n > 1 && lineBuf[0] != "#") begin
                    n = $sscanf(lineBuf, "%s %h %h", opName, operand, expVal);
                    if (n != 3) checker_i.reportFailure({"malformed stimulus line: ", lineBuf});
                    else if (opName == "test") checker_i.startTest(operand);
                    else if (opName == "press") pressButton(operand);
                    else if (opName == "prog") begin
                        programMode = operand[0];
                        stepCycles(1);
                    end else if (opName == "start") begin
                        startRun = operand[0];
                        stepCycles(1);
                    end else if (opName == "rtc") begin
                        rtcTime = operand[23:0];
                        stepCycles(1);
                    end else begin
                        checker_i.expectValue(opName, operand, expVal);
                        stepCycles(1);  // Back to the drive point
                    end
                end
            end
            $fclose(fd);
            checker_i.reportTotals();
            if (checker_i.errCount == 0 &&
                cronoTimer_i.cronoTimer_properties_i.assertFails == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule
